//--- Bender.yml
package:
  name: rv32i_multicycle_core

sources:
  - target: any(simulation, synthesis)
    files:
      - hdl/cpu_pkg.sv
      - hdl/decoder.sv
      - hdl/register_file.sv
      - hdl/alu.sv
      - hdl/request_unit.sv
      - hdl/cpu_core.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/cpu_tb.sv

//--- files.f
hdl/cpu_pkg.sv
hdl/decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/request_unit.sv
hdl/cpu_core.sv
verif/tb_clock_gen.sv
verif/cpu_tb.sv

//--- hdl/alu.sv
// Integer ALU for arithmetic, logic, shifts and compares, plus the branch condition check
module alu (
  input  cpu_pkg::alu_op_e op_i,
  input  cpu_pkg::branch_e branch_i,
  input  cpu_pkg::word_t   a_i,
  input  cpu_pkg::word_t   b_i,
  input  cpu_pkg::word_t   rs1_i,
  input  cpu_pkg::word_t   rs2_i,
  output cpu_pkg::word_t   result_o,
  output logic             taken_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      cpu_pkg::ALU_ADD:    result_o = a_i + b_i;
      cpu_pkg::ALU_SUB:    result_o = a_i - b_i;
      cpu_pkg::ALU_SLL:    result_o = a_i << shamt;
      cpu_pkg::ALU_SLT:    result_o = ($signed(a_i) < $signed(b_i)) ? 32'd1 : 32'd0;
      cpu_pkg::ALU_SLTU:   result_o = (a_i < b_i) ? 32'd1 : 32'd0;
      cpu_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      cpu_pkg::ALU_SRL:    result_o = a_i >> shamt;
      cpu_pkg::ALU_SRA:    result_o = $signed(a_i) >>> shamt;
      cpu_pkg::ALU_OR:     result_o = a_i | b_i;
      cpu_pkg::ALU_AND:    result_o = a_i & b_i;
      cpu_pkg::ALU_PASS_B: result_o = b_i;
      default:             result_o = a_i + b_i;
    endcase
  end

  // Branch test works on the raw register values, not the ALU operands
  always_comb begin
    case (branch_i)
      cpu_pkg::BR_EQ:  taken_o = (rs1_i == rs2_i);
      cpu_pkg::BR_NE:  taken_o = (rs1_i != rs2_i);
      cpu_pkg::BR_LT:  taken_o = ($signed(rs1_i) < $signed(rs2_i));
      cpu_pkg::BR_GE:  taken_o = ($signed(rs1_i) >= $signed(rs2_i));
      cpu_pkg::BR_LTU: taken_o = (rs1_i < rs2_i);
      cpu_pkg::BR_GEU: taken_o = (rs1_i >= rs2_i);
      default:         taken_o = 1'b0;
    endcase
  end

endmodule

//--- hdl/cpu_core.sv
// Multi-cycle RV32I core top level, owns the PC and drives the shared memory bus
module cpu_core (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              busy_i,
  input  cpu_pkg::word_t    rdata_i,
  output cpu_pkg::bus_req_t bus_req_o
);

  cpu_pkg::word_t    pc_q;
  cpu_pkg::word_t    pc_next;
  cpu_pkg::word_t    pc_plus4;
  cpu_pkg::word_t    pc_target;
  cpu_pkg::word_t    instr;
  cpu_pkg::word_t    imm;
  cpu_pkg::word_t    rs1_val;
  cpu_pkg::word_t    rs2_val;
  cpu_pkg::word_t    alu_a;
  cpu_pkg::word_t    alu_b;
  cpu_pkg::word_t    alu_result;
  cpu_pkg::word_t    load_word;
  cpu_pkg::word_t    load_shifted;
  cpu_pkg::word_t    load_value;
  cpu_pkg::word_t    wb_data;
  cpu_pkg::ctrl_t    ctrl;
  cpu_pkg::bus_req_t data_req;
  logic              taken;
  logic              retire;
  logic [1:0]        byte_off;
  logic [4:0]        lane_shift;

  assign pc_plus4  = pc_q + 32'd4;
  assign pc_target = pc_q + imm;

  always_comb begin
    if (ctrl.jalr) begin
      pc_next = {alu_result[cpu_pkg::XLEN-1:1], 1'b0};
    end else if (ctrl.jal || taken) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  // PC moves together with the register file write
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= cpu_pkg::RESET_PC;
    end else if (retire) begin
      pc_q <= pc_next;
    end
  end

  decoder u_decoder (
    .instr_i (instr),
    .ctrl_o  (ctrl),
    .imm_o   (imm)
  );

  register_file u_register_file (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .we_i     (retire && ctrl.reg_write),
    .rs1_i    (instr[19:15]),
    .rs2_i    (instr[24:20]),
    .rd_i     (instr[11:7]),
    .wdata_i  (wb_data),
    .rdata1_o (rs1_val),
    .rdata2_o (rs2_val)
  );

  assign alu_a = ctrl.a_pc ? pc_q : rs1_val;
  assign alu_b = ctrl.b_imm ? imm : rs2_val;

  alu u_alu (
    .op_i     (ctrl.alu_op),
    .branch_i (ctrl.branch),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .rs1_i    (rs1_val),
    .rs2_i    (rs2_val),
    .result_o (alu_result),
    .taken_o  (taken)
  );

  // Byte lane of the effective address
  assign byte_off   = alu_result[1:0];
  assign lane_shift = {byte_off, 3'b000};

  // Word-aligned address, store bytes moved onto their lanes
  always_comb begin
    data_req       = '0;
    data_req.addr  = {alu_result[cpu_pkg::XLEN-1:2], 2'b00};
    data_req.read  = ctrl.mem_read;
    data_req.write = ctrl.mem_write;
    case (ctrl.mem_size)
      cpu_pkg::SIZE_BYTE: begin
        data_req.sel   = 4'b0001 << byte_off;
        data_req.wdata = {24'b0, rs2_val[7:0]} << lane_shift;
      end
      cpu_pkg::SIZE_HALF: begin
        data_req.sel   = byte_off[1] ? 4'b1100 : 4'b0011;
        data_req.wdata = {16'b0, rs2_val[15:0]} << {byte_off[1], 4'b0000};
      end
      default: begin
        data_req.sel   = 4'hF;
        data_req.wdata = rs2_val;
      end
    endcase
  end

  request_unit u_request_unit (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .pc_i       (pc_q),
    .data_req_i (data_req),
    .busy_i     (busy_i),
    .rdata_i    (rdata_i),
    .bus_req_o  (bus_req_o),
    .instr_o    (instr),
    .rdata_o    (load_word),
    .retire_o   (retire)
  );

  // Load lane down to bit 0, then extend
  assign load_shifted = load_word >> lane_shift;

  always_comb begin
    case (ctrl.mem_size)
      cpu_pkg::SIZE_BYTE: begin
        load_value = ctrl.load_unsigned ? {24'b0, load_shifted[7:0]}
                                        : {{24{load_shifted[7]}}, load_shifted[7:0]};
      end
      cpu_pkg::SIZE_HALF: begin
        load_value = ctrl.load_unsigned ? {16'b0, load_shifted[15:0]}
                                        : {{16{load_shifted[15]}}, load_shifted[15:0]};
      end
      default: load_value = load_word;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      cpu_pkg::WB_LOAD: wb_data = load_value;
      cpu_pkg::WB_PC4:  wb_data = pc_plus4;
      default:          wb_data = alu_result;
    endcase
  end

endmodule

//--- hdl/cpu_pkg.sv
// Shared widths, opcodes, control encodings and bus request layout used by every core module
package cpu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // Fetch address after reset
  localparam word_t RESET_PC = '0;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } branch_e;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_e;

  // Write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_e;

  typedef struct packed {
    alu_op_e   alu_op;
    logic      a_pc;
    logic      b_imm;
    branch_e   branch;
    logic      jal;
    logic      jalr;
    logic      mem_read;
    logic      mem_write;
    mem_size_e mem_size;
    logic      load_unsigned;
    logic      reg_write;
    wb_sel_e   wb_sel;
  } ctrl_t;

  // One transfer on the shared memory bus
  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] sel;
    logic       write;
    logic       read;
  } bus_req_t;

endpackage

//--- hdl/decoder.sv
// Instruction decoder, turns the held instruction into core controls and its immediate
module decoder (
  input  cpu_pkg::word_t instr_i,
  output cpu_pkg::ctrl_t ctrl_o,
  output cpu_pkg::word_t imm_o
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic               bit30;
  cpu_pkg::word_t     imm_i;
  cpu_pkg::word_t     imm_s;
  cpu_pkg::word_t     imm_b;
  cpu_pkg::word_t     imm_u;
  cpu_pkg::word_t     imm_j;
  cpu_pkg::mem_size_e size_f3;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign bit30  = instr_i[30];

  // Immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // Access width for loads and stores
  assign size_f3 = (funct3[1:0] == 2'b00) ? cpu_pkg::SIZE_BYTE :
                   (funct3[1:0] == 2'b01) ? cpu_pkg::SIZE_HALF : cpu_pkg::SIZE_WORD;

  // Shared by OP and OP-IMM, alt picks SUB or SRA
  function automatic cpu_pkg::alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
    cpu_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
      3'b001:  op = cpu_pkg::ALU_SLL;
      3'b010:  op = cpu_pkg::ALU_SLT;
      3'b011:  op = cpu_pkg::ALU_SLTU;
      3'b100:  op = cpu_pkg::ALU_XOR;
      3'b101:  op = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
      3'b110:  op = cpu_pkg::ALU_OR;
      default: op = cpu_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    // Anything not listed, FENCE and SYSTEM included, retires as a no-op
    ctrl_o = '0;
    imm_o  = imm_i;
    case (opcode)
      cpu_pkg::OPC_LUI: begin
        ctrl_o.alu_op    = cpu_pkg::ALU_PASS_B;
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_u;
      end
      cpu_pkg::OPC_AUIPC: begin
        ctrl_o.a_pc      = 1'b1;
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.reg_write = 1'b1;
        imm_o            = imm_u;
      end
      cpu_pkg::OPC_JAL: begin
        ctrl_o.jal       = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.wb_sel    = cpu_pkg::WB_PC4;
        imm_o            = imm_j;
      end
      cpu_pkg::OPC_JALR: begin
        ctrl_o.jalr      = 1'b1;
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.wb_sel    = cpu_pkg::WB_PC4;
      end
      cpu_pkg::OPC_BRANCH: begin
        imm_o = imm_b;
        case (funct3)
          3'b000:  ctrl_o.branch = cpu_pkg::BR_EQ;
          3'b001:  ctrl_o.branch = cpu_pkg::BR_NE;
          3'b100:  ctrl_o.branch = cpu_pkg::BR_LT;
          3'b101:  ctrl_o.branch = cpu_pkg::BR_GE;
          3'b110:  ctrl_o.branch = cpu_pkg::BR_LTU;
          3'b111:  ctrl_o.branch = cpu_pkg::BR_GEU;
          default: ctrl_o.branch = cpu_pkg::BR_NONE;
        endcase
      end
      cpu_pkg::OPC_LOAD: begin
        ctrl_o.b_imm         = 1'b1;
        ctrl_o.mem_read      = 1'b1;
        ctrl_o.mem_size      = size_f3;
        ctrl_o.load_unsigned = funct3[2];
        ctrl_o.reg_write     = 1'b1;
        ctrl_o.wb_sel        = cpu_pkg::WB_LOAD;
      end
      cpu_pkg::OPC_STORE: begin
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.mem_write = 1'b1;
        ctrl_o.mem_size  = size_f3;
        imm_o            = imm_s;
      end
      cpu_pkg::OPC_OPIMM: begin
        // Bit 30 only matters for the right shifts here
        ctrl_o.alu_op    = funct_to_alu(funct3, bit30 && (funct3 == 3'b101));
        ctrl_o.b_imm     = 1'b1;
        ctrl_o.reg_write = 1'b1;
      end
      cpu_pkg::OPC_OP: begin
        ctrl_o.alu_op    = funct_to_alu(funct3, bit30);
        ctrl_o.reg_write = 1'b1;
      end
      default: ctrl_o = '0;
    endcase
  end

endmodule

//--- hdl/register_file.sv
// Integer register file with two combinational read ports and one clocked write port
module register_file (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              we_i,
  input  cpu_pkg::reg_idx_t rs1_i,
  input  cpu_pkg::reg_idx_t rs2_i,
  input  cpu_pkg::reg_idx_t rd_i,
  input  cpu_pkg::word_t    wdata_i,
  output cpu_pkg::word_t    rdata1_o,
  output cpu_pkg::word_t    rdata2_o
);

  // x1 to x31, x0 has no storage
  cpu_pkg::word_t regs [1:31];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // x0 always reads zero
  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- hdl/request_unit.sv
// Bus sequencer that runs fetch and data phases one at a time and tells the core when to retire
module request_unit (
  input  logic              clk,
  input  logic              arst_n_i,
  input  cpu_pkg::word_t    pc_i,
  input  cpu_pkg::bus_req_t data_req_i,
  input  logic              busy_i,
  input  cpu_pkg::word_t    rdata_i,
  output cpu_pkg::bus_req_t bus_req_o,
  output cpu_pkg::word_t    instr_o,
  output cpu_pkg::word_t    rdata_o,
  output logic              retire_o
);

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_DATA,
    ST_NEXT
  } state_e;

  state_e         state_q;
  state_e         state_d;
  logic           data_phase;
  logic           fetch_done;
  cpu_pkg::word_t instr_q;

  // Decoded instruction asks for a load or store
  assign data_phase = data_req_i.read | data_req_i.write;

  assign fetch_done = (state_q == ST_FETCH) && !busy_i;

  always_comb begin
    state_d = state_q;
    // Back-pressure freezes the sequence in every state
    if (!busy_i) begin
      case (state_q)
        ST_NEXT:  state_d = ST_FETCH;
        ST_FETCH: state_d = ST_EXEC;
        ST_EXEC:  state_d = data_phase ? ST_DATA : ST_FETCH;
        ST_DATA:  state_d = ST_FETCH;
        default:  state_d = ST_NEXT;
      endcase
    end
  end

  // Comes out of reset in NEXT so no strobe shows until the first fetch
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_NEXT;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      instr_q <= rdata_i;
    end
  end

  // Word read at the PC while fetching and the core's own request in the data phase
  always_comb begin
    case (state_q)
      ST_FETCH: begin
        bus_req_o       = '0;
        bus_req_o.addr  = pc_i;
        bus_req_o.sel   = 4'hF;
        bus_req_o.read  = 1'b1;
      end
      ST_DATA: bus_req_o = data_req_i;
      default: bus_req_o = '0;
    endcase
  end

  // Non-memory ops retire one cycle after fetch and memory ops on data completion
  assign retire_o = !busy_i &&
                    (((state_q == ST_EXEC) && !data_phase) || (state_q == ST_DATA));

  assign instr_o = instr_q;

  // Load data goes straight to write-back on the completing beat
  assign rdata_o = rdata_i;

endmodule

//--- verif/cpu_tb.sv
// Core testbench that runs a random program from bus memory and checks every bus transfer against a model
module cpu_tb;

  localparam int             N_INSTR    = 64;
  localparam int             MEM_WORDS  = 512;
  localparam int             DATA_WORD0 = 32'h400 / 4;
  localparam int             DATA_WORDS = 64;
  // Up to five cycles per phase, two phases per instruction, plus reset and margin
  localparam int             MAX_CYCLES = N_INSTR * 2 * 5 + 10 + 60;
  localparam cpu_pkg::word_t END_PC     = (N_INSTR - 1) * 4;

  logic              clk;
  logic              arst_n;
  logic              busy;
  cpu_pkg::word_t    rdata;
  cpu_pkg::bus_req_t bus_req;

  logic [31:0]       lfsr_q;
  cpu_pkg::word_t    bus_mem [0:MEM_WORDS-1];
  cpu_pkg::word_t    ref_mem [0:MEM_WORDS-1];
  cpu_pkg::word_t    ref_regs [0:31];
  cpu_pkg::word_t    ref_pc;
  logic              data_pending;
  cpu_pkg::bus_req_t exp_data;
  cpu_pkg::bus_req_t held_req;
  logic              in_transfer;
  logic              run_done;
  int                wait_left;
  int                cycles;

  tb_clock_gen u_tb_clock_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  cpu_core u_cpu_core (
    .clk       (clk),
    .arst_n_i  (arst_n),
    .busy_i    (busy),
    .rdata_i   (rdata),
    .bus_req_o (bus_req)
  );

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    abort_run();
  endtask

  task automatic compare_req(input string name, input cpu_pkg::bus_req_t exp,
                             input cpu_pkg::bus_req_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic compare_word(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // Galois LFSR stepped once for every bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic logic [4:0] pick_rs();
    return rand_bits(5);
  endfunction

  // x1 keeps the data base and x2 the jump base
  function automatic logic [4:0] pick_rd();
    logic [4:0] rd;
    rd = rand_bits(5);
    return (rd < 5'd3) ? 5'd0 : rd;
  endfunction

  // Forward distance in instructions that never passes the final self-jump
  function automatic int fwd_steps(input int idx);
    int k;
    k = 2 + rand_bits(2);
    return (idx + k > N_INSTR - 1) ? (N_INSTR - 1 - idx) : k;
  endfunction

  function automatic logic [11:0] mem_offset(input logic [2:0] f3);
    logic [7:0] off;
    off = rand_bits(8);
    if (f3[1]) off[1:0] = 2'b00;
    else if (f3[0]) off[0] = 1'b0;
    return {4'b0, off};
  endfunction

  function automatic cpu_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
  endfunction

  function automatic cpu_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic cpu_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], cpu_pkg::OPC_STORE};
  endfunction

  function automatic cpu_pkg::word_t b_type(input logic [12:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::OPC_BRANCH};
  endfunction

  function automatic cpu_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic cpu_pkg::word_t j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::OPC_JAL};
  endfunction

  task automatic place(input int idx, input cpu_pkg::word_t ins);
    bus_mem[idx] = ins;
    ref_mem[idx] = ins;
  endtask

  task automatic build_program();
    int             i;
    logic [3:0]     kind;
    logic [2:0]     f3;
    logic [11:0]    imm;
    logic [12:0]    boff;
    logic [20:0]    joff;
    logic           alt;
    cpu_pkg::word_t ins;
    // ADDI x1, x0, 0x400 points x1 at the data region
    place(0, i_type(12'h400, 5'd0, 3'd0, 5'd1, cpu_pkg::OPC_OPIMM));
    i = 1;
    while (i < N_INSTR - 1) begin
      kind = rand_bits(4);
      f3   = rand_bits(3);
      alt  = rand_bits(1);
      case (kind)
        4'd0: ins = u_type(rand_bits(20), pick_rd(), cpu_pkg::OPC_LUI);
        4'd1: ins = u_type(rand_bits(20), pick_rd(), cpu_pkg::OPC_AUIPC);
        4'd2: begin
          joff = fwd_steps(i) * 4;
          ins  = j_type(joff, pick_rd());
        end
        4'd3: begin
          if (i < N_INSTR - 2) begin
            place(i, u_type(20'd0, 5'd2, cpu_pkg::OPC_LUI));
            i++;
            // Odd targets check that bit 0 gets cleared
            imm = (i + fwd_steps(i)) * 4 + alt;
            ins = i_type(imm, 5'd2, 3'd0, pick_rd(), cpu_pkg::OPC_JALR);
          end else begin
            ins = i_type(rand_bits(12), pick_rs(), 3'd0, pick_rd(), cpu_pkg::OPC_OPIMM);
          end
        end
        4'd4, 4'd5: begin
          if (f3[2:1] == 2'b01) f3 = f3 + 3'd2;
          boff = fwd_steps(i) * 4;
          ins  = b_type(boff, pick_rs(), pick_rs(), f3);
        end
        4'd6, 4'd7: begin
          if (f3 == 3'd3 || f3 > 3'd5) f3 = f3 & 3'b101;
          ins = i_type(mem_offset(f3), 5'd1, f3, pick_rd(), cpu_pkg::OPC_LOAD);
        end
        4'd8, 4'd9: begin
          f3  = f3 % 3;
          ins = s_type(mem_offset(f3), pick_rs(), 5'd1, f3);
        end
        4'd10, 4'd11, 4'd12: begin
          imm = rand_bits(12);
          if (f3 == 3'd1) imm = {7'b0, imm[4:0]};
          if (f3 == 3'd5) imm = {1'b0, alt, 5'b0, imm[4:0]};
          ins = i_type(imm, pick_rs(), f3, pick_rd(), cpu_pkg::OPC_OPIMM);
        end
        default: begin
          alt = alt && (f3 == 3'd0 || f3 == 3'd5);
          ins = r_type({1'b0, alt, 5'b0}, pick_rs(), pick_rs(), f3, pick_rd());
        end
      endcase
      place(i, ins);
      i++;
    end
    place(N_INSTR - 1, j_type(21'd0, 5'd0));
  endtask

  function automatic cpu_pkg::word_t compute_op(input logic [2:0] f3, input logic alt,
                                                input cpu_pkg::word_t x,
                                                input cpu_pkg::word_t y);
    cpu_pkg::word_t r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3: r = (x < y) ? 32'd1 : 32'd0;
      3'd4: r = x ^ y;
      3'd5: begin
        if (alt) r = $signed(x) >>> y[4:0];
        else r = x >> y[4:0];
      end
      3'd6: r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input cpu_pkg::word_t x,
                                        input cpu_pkg::word_t y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      3'd7: return x >= y;
      default: return 1'b0;
    endcase
  endfunction

  // Bytes touched by an access of the given width starting at the given offset
  function automatic logic [3:0] lane_sel(input logic [2:0] f3, input logic [1:0] off);
    int         nbytes;
    logic [3:0] sel;
    nbytes = 1 << f3[1:0];
    sel    = '0;
    for (int j = 0; j < 4; j++) begin
      if (j >= off && j < off + nbytes) sel[j] = 1'b1;
    end
    return sel;
  endfunction

  // Store bytes go to the lanes their addresses select and the rest stay zero
  function automatic cpu_pkg::word_t lane_data(input logic [2:0] f3, input cpu_pkg::word_t v,
                                               input logic [1:0] off);
    cpu_pkg::word_t d;
    logic [3:0]     sel;
    d   = '0;
    sel = lane_sel(f3, off);
    for (int j = 0; j < 4; j++) begin
      if (sel[j]) d[8*j +: 8] = v[8*(j - off) +: 8];
    end
    return d;
  endfunction

  function automatic cpu_pkg::word_t extend_load(input logic [2:0] f3, input cpu_pkg::word_t w,
                                                 input logic [1:0] off);
    cpu_pkg::word_t s;
    s = w >> (8 * off);
    case (f3)
      3'd0: return {{24{s[7]}}, s[7:0]};
      3'd1: return {{16{s[15]}}, s[15:0]};
      3'd4: return {24'b0, s[7:0]};
      3'd5: return {16'b0, s[15:0]};
      default: return s;
    endcase
  endfunction

  function automatic cpu_pkg::word_t merge_bytes(input cpu_pkg::word_t old,
                                                 input cpu_pkg::word_t data,
                                                 input logic [3:0] sel);
    cpu_pkg::word_t r;
    r = old;
    for (int j = 0; j < 4; j++) begin
      if (sel[j]) r[8*j +: 8] = data[8*j +: 8];
    end
    return r;
  endfunction

  // Runs one instruction on the model and records the data transfer it should make
  task automatic model_exec();
    cpu_pkg::word_t ins;
    cpu_pkg::word_t rs1v;
    cpu_pkg::word_t rs2v;
    cpu_pkg::word_t imm_i;
    cpu_pkg::word_t ea;
    cpu_pkg::word_t res;
    cpu_pkg::word_t nxt;
    logic [2:0]     f3;
    logic           wr;
    ins   = ref_mem[ref_pc[10:2]];
    f3    = ins[14:12];
    rs1v  = ref_regs[ins[19:15]];
    rs2v  = ref_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    nxt   = ref_pc + 32'd4;
    res   = '0;
    wr    = 1'b1;
    case (ins[6:0])
      cpu_pkg::OPC_LUI:   res = {ins[31:12], 12'b0};
      cpu_pkg::OPC_AUIPC: res = ref_pc + {ins[31:12], 12'b0};
      cpu_pkg::OPC_JAL: begin
        res = nxt;
        nxt = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      cpu_pkg::OPC_JALR: begin
        res = nxt;
        nxt = (rs1v + imm_i) & ~32'd1;
      end
      cpu_pkg::OPC_BRANCH: begin
        wr = 1'b0;
        if (branch_taken(f3, rs1v, rs2v)) begin
          nxt = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      cpu_pkg::OPC_LOAD: begin
        ea             = rs1v + imm_i;
        res            = extend_load(f3, ref_mem[ea[10:2]], ea[1:0]);
        exp_data       = '0;
        exp_data.addr  = {ea[31:2], 2'b00};
        exp_data.sel   = lane_sel(f3, ea[1:0]);
        exp_data.read  = 1'b1;
        data_pending   = 1'b1;
      end
      cpu_pkg::OPC_STORE: begin
        wr             = 1'b0;
        ea             = rs1v + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        exp_data       = '0;
        exp_data.addr  = {ea[31:2], 2'b00};
        exp_data.wdata = lane_data(f3, rs2v, ea[1:0]);
        exp_data.sel   = lane_sel(f3, ea[1:0]);
        exp_data.write = 1'b1;
        data_pending   = 1'b1;
        ref_mem[ea[10:2]] = merge_bytes(ref_mem[ea[10:2]], exp_data.wdata, exp_data.sel);
      end
      cpu_pkg::OPC_OPIMM: res = compute_op(f3, ins[30] && (f3 == 3'd5), rs1v, imm_i);
      cpu_pkg::OPC_OP:    res = compute_op(f3, ins[30], rs1v, rs2v);
      default:            wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0) ref_regs[ins[11:7]] = res;
    ref_pc = nxt;
  endtask

  task automatic start_transfer(input cpu_pkg::bus_req_t req);
    cpu_pkg::bus_req_t exp;
    cpu_pkg::bus_req_t seen;
    if (req.addr >= MEM_WORDS * 4) report_failure("bus address outside the memory model");
    if (data_pending) begin
      seen = req;
      // Write data means nothing on a read
      if (req.read) seen.wdata = '0;
      compare_req("data request", exp_data, seen);
      data_pending = 1'b0;
    end else begin
      exp      = '0;
      exp.addr = ref_pc;
      exp.sel  = 4'hF;
      exp.read = 1'b1;
      compare_req("instruction fetch", exp, req);
      if (req.addr == END_PC) run_done = 1'b1;
      else model_exec();
    end
    held_req    = req;
    in_transfer = 1'b1;
    wait_left   = rand_bits(2);
  endtask

  // One bus cycle of the memory model run just after each rising edge
  task automatic serve_bus();
    cpu_pkg::bus_req_t req;
    req = bus_req;
    cycles++;
    if (cycles > MAX_CYCLES) report_failure("timeout, the program never reached its last jump");
    if (!arst_n) begin
      if (req.read || req.write) report_failure("bus strobe high while reset is held");
    end else if (req.read && req.write) begin
      report_failure("read and write strobes high in the same cycle");
    end else if (!req.read && !req.write) begin
      if (in_transfer) report_failure("strobe dropped before the transfer completed");
      busy = 1'b0;
    end else begin
      if (in_transfer) compare_req("request held under busy", held_req, req);
      else start_transfer(req);
      if (wait_left > 0) begin
        busy = 1'b1;
        wait_left--;
      end else begin
        busy        = 1'b0;
        in_transfer = 1'b0;
        if (req.read) rdata = bus_mem[req.addr[10:2]];
        else bus_mem[req.addr[10:2]] = merge_bytes(bus_mem[req.addr[10:2]], req.wdata, req.sel);
      end
    end
  endtask

  initial begin
    busy         = 1'b0;
    rdata        = '0;
    lfsr_q       = 32'h3921;
    ref_pc       = cpu_pkg::RESET_PC;
    data_pending = 1'b0;
    in_transfer  = 1'b0;
    run_done     = 1'b0;
    wait_left    = 0;
    cycles       = 0;
    exp_data     = '0;
    held_req     = '0;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    // Fill pattern follows the word address
    for (int a = 0; a < MEM_WORDS; a++) begin
      bus_mem[a] = (a * 32'h9E37_79B1) ^ 32'h6D2B_79F5;
      ref_mem[a] = bus_mem[a];
    end
    build_program();
    while (!run_done) begin
      @(posedge clk);
      #2;
      serve_bus();
    end
    for (int w = 0; w < DATA_WORDS; w++) begin
      compare_word("final data region", ref_mem[DATA_WORD0 + w], bus_mem[DATA_WORD0 + w]);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- verif/tb_clock_gen.sv
// Testbench clock and reset source, 20 unit period with reset held low for the first ten cycles
module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    // Released off the edge like every other input
    #2 arst_n_o = 1'b1;
  end

endmodule
